// ==== design/blob_params.svh ====
`ifndef BLOB_PARAMS_SVH
`define BLOB_PARAMS_SVH

// Frame geometry in pixels
`define IMG_W 16
`define IMG_H 12
`define IMG_MARGIN 1 // Border ring never scanned or filled

// Datapath widths
`define COORD_W 8
`define ADDR_W 10
`define WORD_W 32

// Record area, two words per label
`define REC_BASE 512

// Fill stack entries
`define STACK_DEPTH 64

// Labels 0 and 1 are pixel values
`define FIRST_LABEL 2

`endif

// ==== design/blob_pkg.sv ====
`include "blob_params.svh"

package blob_pkg;

	typedef struct packed {
		logic [`COORD_W-1:0] x;
		logic [`COORD_W-1:0] y;
	} coord_t;

	// Layout of record word 1
	typedef struct packed {
		logic [7:0] min_x;
		logic [7:0] min_y;
		logic [7:0] max_x;
		logic [7:0] max_y;
	} bbox_t;

	typedef struct packed {
		logic [15:0] count;
		bbox_t bbox;
	} stats_t;

	typedef enum logic [1:0] {
		op_idle,
		op_read_pix,
		op_write_label,
		op_write_rec
	} mem_op_t;

	// Record writes reuse pos and label as payload
	// Word 0 has the count in label, word 1 has min corner in pos and max corner in label
	typedef struct packed {
		mem_op_t op;
		coord_t pos;
		logic [15:0] label;
		logic rec_word;
	} mem_req_t;

	typedef struct packed {
		logic [`WORD_W-17:0] zero;
		logic [15:0] value;
	} label_word_t;

	typedef union packed {
		label_word_t lbl; // Pixel labels and blob count
		bbox_t bbox;
	} mem_word_u;

endpackage

// ==== design/fill_stack.sv ====
`timescale 1ns/1ps
`include "blob_params.svh"

module fill_stack (
	input logic clk,
	input logic rst_n,
	input logic pause,
	input logic push,
	input logic pop,
	input blob_pkg::coord_t push_coord,
	output blob_pkg::coord_t top,
	output logic empty
);

	localparam int ptr_w = $clog2(`STACK_DEPTH);
	localparam logic [ptr_w:0] depth = `STACK_DEPTH;

	blob_pkg::coord_t mem [`STACK_DEPTH];
	logic [ptr_w:0] ptr; // Entries in use
	logic [ptr_w:0] ptr_top;
	logic full;

	assign ptr_top = ptr - 1'b1;
	assign top = mem[ptr_top[ptr_w-1:0]]; // Most recent push
	assign empty = (ptr == '0);
	assign full = (ptr == depth);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (!pause) begin
			if (push)
				ptr <= ptr + 1'b1;
			else if (pop)
				ptr <= ptr - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!pause && push)
			mem[ptr[ptr_w-1:0]] <= push_coord;
	end

	assert property (@(posedge clk) disable iff (!rst_n) (pop && !pause) |-> !empty)
		else $error("fill_stack: pop while empty");
	assert property (@(posedge clk) disable iff (!rst_n) (push && !pause) |-> !full)
		else $error("fill_stack: push while full");

endmodule

// ==== design/blob_stats.sv ====
`timescale 1ns/1ps

module blob_stats (
	input logic clk,
	input logic rst_n,
	input logic pause,
	input logic stats_clear,
	input logic stats_add,
	input blob_pkg::coord_t stats_coord,
	output blob_pkg::stats_t stats
);

	logic [15:0] count;
	blob_pkg::bbox_t bbox;

	assign stats = '{count: count, bbox: bbox};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (!pause) begin
			if (stats_clear)
				count <= '0;
			else if (stats_add)
				count <= count + 16'd1;
		end
	end

	// Box starts at the first pixel, then only grows
	always_ff @(posedge clk) begin
		if (!pause && stats_add) begin
			if (count == '0) begin
				bbox <= '{stats_coord.x, stats_coord.y, stats_coord.x, stats_coord.y};
			end else begin
				if (stats_coord.x < bbox.min_x)
					bbox.min_x <= stats_coord.x;
				if (stats_coord.y < bbox.min_y)
					bbox.min_y <= stats_coord.y;
				if (stats_coord.x > bbox.max_x)
					bbox.max_x <= stats_coord.x;
				if (stats_coord.y > bbox.max_y)
					bbox.max_y <= stats_coord.y;
			end
		end
	end

endmodule

// ==== design/mem_access.sv ====
`timescale 1ns/1ps
`include "blob_params.svh"

module mem_access (
	input logic clk,
	input logic rst_n,
	input logic pause,
	input blob_pkg::mem_req_t req,
	input logic [`WORD_W-1:0] data_read,
	output logic [`ADDR_W-1:0] address,
	output blob_pkg::mem_word_u data_write,
	output logic wren,
	output logic pix_zero
);

	logic [15:0] rec_label; // Label of the blob being filled
	logic [`ADDR_W-1:0] pix_addr, addr_next;
	blob_pkg::mem_word_u word_next;
	logic wr_next, wr_q;

	assign pix_addr = `ADDR_W'(req.pos.y) * `ADDR_W'(`IMG_W) + `ADDR_W'(req.pos.x);

	always_comb begin
		addr_next = address; // Idle holds the address so read data stays put
		word_next = data_write;
		wr_next = 1'b0;
		case (req.op)
			blob_pkg::op_read_pix: addr_next = pix_addr;
			blob_pkg::op_write_label: begin
				addr_next = pix_addr;
				word_next = '0;
				word_next.lbl.value = req.label;
				wr_next = 1'b1;
			end
			blob_pkg::op_write_rec: begin
				addr_next = `ADDR_W'(`REC_BASE) + `ADDR_W'({rec_label, req.rec_word});
				word_next = '0;
				if (req.rec_word)
					word_next.bbox = '{req.pos.x, req.pos.y, req.label[15:8], req.label[7:0]};
				else
					word_next.lbl.value = req.label; // Pixel count
				wr_next = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			address <= '0;
			wr_q <= 1'b0;
			pix_zero <= 1'b0;
			rec_label <= '0;
		end else if (!pause) begin
			address <= addr_next;
			wr_q <= wr_next;
			pix_zero <= (data_read == '0);
			if (req.op == blob_pkg::op_write_label)
				rec_label <= req.label;
		end
	end

	always_ff @(posedge clk) begin
		if (!pause)
			data_write <= word_next;
	end

	assign wren = wr_q && !pause; // Held write lands once pause drops

	assert property (@(posedge clk) disable iff (!rst_n)
		wren |-> (address < `ADDR_W'(`IMG_W * `IMG_H)) || (address >= `ADDR_W'(`REC_BASE)))
		else $error("mem_access: write outside frame and record area");

endmodule

// ==== design/blob_ctrl.sv ====
`timescale 1ns/1ps
`include "blob_params.svh"

module blob_ctrl (
	input logic clk,
	input logic rst_n,
	input logic enable,
	input logic pause,
	input logic pix_zero,
	input blob_pkg::coord_t top,
	input logic empty,
	input blob_pkg::stats_t stats,
	output logic push,
	output logic pop,
	output logic stats_clear,
	output logic stats_add,
	output blob_pkg::coord_t push_coord,
	output blob_pkg::coord_t stats_coord,
	output blob_pkg::mem_req_t req,
	output logic done
);

	// Interior bounds, inclusive
	localparam logic [`COORD_W-1:0] x_lo = `IMG_MARGIN;
	localparam logic [`COORD_W-1:0] x_hi = `IMG_W - `IMG_MARGIN - 1;
	localparam logic [`COORD_W-1:0] y_lo = `IMG_MARGIN;
	localparam logic [`COORD_W-1:0] y_hi = `IMG_H - `IMG_MARGIN - 1;
	localparam int rd_wait = 2; // Idle cycles between a read and its pix_zero

	// Every read state sits right before its check state
	typedef enum logic [4:0] {
		s_idle, s_scan_rd, s_scan_chk, s_scan_next, s_wait,
		s_pop, s_up_rd, s_up_chk, s_fill_rd, s_fill_chk,
		s_left_rd, s_left_chk, s_right_rd, s_right_chk,
		s_rec0, s_rec_gap, s_rec1, s_done
	} state_t;

	state_t state, ret_state;
	logic [1:0] wait_cnt;
	logic en_seen; // Enable was high last cycle
	logic [15:0] label;
	blob_pkg::coord_t scan_pos, cur_pos, left_pos, right_pos;
	logic span_l, span_r;
	logic seed_fill, cur_fill, left_fill, right_fill;

	function automatic logic interior(blob_pkg::coord_t p);
		return (p.x >= x_lo) && (p.x <= x_hi) && (p.y >= y_lo) && (p.y <= y_hi);
	endfunction

	assign left_pos = '{x: cur_pos.x - 1'b1, y: cur_pos.y};
	assign right_pos = '{x: cur_pos.x + 1'b1, y: cur_pos.y};

	// Fillable means zero and strictly inside the margin
	assign seed_fill = pix_zero && interior(scan_pos);
	assign cur_fill = pix_zero && interior(cur_pos);
	assign left_fill = pix_zero && interior(left_pos);
	assign right_fill = pix_zero && interior(right_pos);
	assign stats_coord = cur_pos;

	always_comb begin
		req = '0;
		push = 1'b0;
		pop = 1'b0;
		stats_clear = 1'b0;
		stats_add = 1'b0;
		push_coord = cur_pos;
		case (state)
			s_scan_rd: begin
				req.op = blob_pkg::op_read_pix;
				req.pos = scan_pos;
			end
			s_scan_chk: begin // Seed of a new blob
				push = seed_fill;
				push_coord = scan_pos;
				stats_clear = seed_fill;
			end
			s_pop: pop = !empty;
			s_up_rd, s_fill_rd: begin
				req.op = blob_pkg::op_read_pix;
				req.pos = cur_pos;
			end
			s_fill_chk: if (cur_fill) begin
				req.op = blob_pkg::op_write_label;
				req.pos = cur_pos;
				req.label = label;
				stats_add = 1'b1;
			end
			s_left_rd: begin
				req.op = blob_pkg::op_read_pix;
				req.pos = left_pos;
			end
			s_left_chk: begin
				push = left_fill && !span_l; // Only the first pixel of a run
				push_coord = left_pos;
			end
			s_right_rd: begin
				req.op = blob_pkg::op_read_pix;
				req.pos = right_pos;
			end
			s_right_chk: begin
				push = right_fill && !span_r;
				push_coord = right_pos;
			end
			s_rec0: begin
				req.op = blob_pkg::op_write_rec;
				req.label = stats.count;
			end
			s_rec1: begin
				req.op = blob_pkg::op_write_rec;
				req.rec_word = 1'b1;
				req.pos = '{x: stats.bbox.min_x, y: stats.bbox.min_y};
				req.label = {stats.bbox.max_x, stats.bbox.max_y};
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_idle;
			ret_state <= s_idle;
			wait_cnt <= '0;
			en_seen <= 1'b0;
			done <= 1'b0;
			label <= '0;
			scan_pos <= '0;
			cur_pos <= '0;
			span_l <= 1'b0;
			span_r <= 1'b0;
		end else if (!pause) begin
			en_seen <= enable;
			case (state)
				s_idle: if (enable && en_seen) begin
					scan_pos <= '{x: x_lo, y: y_lo};
					label <= 16'(`FIRST_LABEL - 1);
					state <= s_scan_rd;
				end
				s_scan_rd, s_up_rd, s_fill_rd, s_left_rd, s_right_rd: begin
					ret_state <= state_t'(state + 1'b1);
					state <= s_wait;
				end
				s_wait: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == 2'(rd_wait - 1)) begin
						wait_cnt <= '0;
						state <= ret_state;
					end
				end
				s_scan_chk: begin
					if (seed_fill)
						label <= label + 1'b1;
					state <= seed_fill ? s_pop : s_scan_next;
				end
				s_scan_next: begin
					state <= s_scan_rd;
					if (scan_pos.x != x_hi) begin
						scan_pos.x <= scan_pos.x + 1'b1;
					end else begin
						scan_pos.x <= x_lo;
						scan_pos.y <= scan_pos.y + 1'b1;
						if (scan_pos.y == y_hi) begin // Frame finished
							state <= s_done;
							done <= 1'b1;
						end
					end
				end
				s_pop: begin
					if (empty) begin
						state <= s_rec0;
					end else begin
						cur_pos <= top;
						state <= s_up_rd;
					end
				end
				s_up_chk: begin
					if (cur_fill) begin
						cur_pos.y <= cur_pos.y - 1'b1;
						state <= s_up_rd;
					end else begin // Top edge found, fill down from below it
						cur_pos.y <= cur_pos.y + 1'b1;
						span_l <= 1'b0;
						span_r <= 1'b0;
						state <= s_fill_rd;
					end
				end
				s_fill_chk: state <= cur_fill ? s_left_rd : s_pop;
				s_left_chk: begin
					span_l <= left_fill;
					state <= s_right_rd;
				end
				s_right_chk: begin
					span_r <= right_fill;
					cur_pos.y <= cur_pos.y + 1'b1;
					state <= s_fill_rd;
				end
				s_rec0: state <= s_rec_gap; // Keep writes two cycles apart
				s_rec_gap: state <= s_rec1;
				s_rec1: state <= s_scan_next;
				s_done: if (!enable) begin
					done <= 1'b0;
					state <= s_idle;
				end
				default: state <= s_idle;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) !(push && pop))
		else $error("blob_ctrl: push and pop in the same cycle");

endmodule

// ==== design/blob_extraction.sv ====
`timescale 1ns/1ps
`include "blob_params.svh"

module blob_extraction (
	input logic clk,
	input logic rst_n,
	input logic enable,
	input logic pause,
	input logic [`WORD_W-1:0] data_read,
	output logic [`ADDR_W-1:0] address,
	output blob_pkg::mem_word_u data_write,
	output logic wren,
	output logic done
);

	logic pix_zero;
	logic push, pop, empty;
	logic stats_clear, stats_add;
	blob_pkg::coord_t top, push_coord, stats_coord;
	blob_pkg::stats_t stats;
	blob_pkg::mem_req_t req;

	blob_ctrl u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.enable(enable),
		.pause(pause),
		.pix_zero(pix_zero),
		.top(top),
		.empty(empty),
		.stats(stats),
		.push(push),
		.pop(pop),
		.stats_clear(stats_clear),
		.stats_add(stats_add),
		.push_coord(push_coord),
		.stats_coord(stats_coord),
		.req(req),
		.done(done)
	);

	fill_stack u_stack (
		.clk(clk),
		.rst_n(rst_n),
		.pause(pause),
		.push(push),
		.pop(pop),
		.push_coord(push_coord),
		.top(top),
		.empty(empty)
	);

	blob_stats u_stats (
		.clk(clk),
		.rst_n(rst_n),
		.pause(pause),
		.stats_clear(stats_clear),
		.stats_add(stats_add),
		.stats_coord(stats_coord),
		.stats(stats)
	);

	// Single port to the external frame memory
	mem_access u_mem (
		.clk(clk),
		.rst_n(rst_n),
		.pause(pause),
		.req(req),
		.data_read(data_read),
		.address(address),
		.data_write(data_write),
		.wren(wren),
		.pix_zero(pix_zero)
	);

endmodule

// ==== test/tb_blob_extraction.sv ====
`timescale 1ns/1ps
`include "blob_params.svh"

module tb_blob_extraction;

	localparam int n_tests = 4;
	localparam int test_words = 13; // Flag word then one word per frame row
	localparam int area = `IMG_W * `IMG_H;
	localparam int mem_words = 1 << `ADDR_W;
	localparam int limit = n_tests * 20 * area;

	logic clk = 1'b0;
	logic rst_n;
	logic enable;
	logic pause = 1'b0;
	logic [`WORD_W-1:0] data_read = '0;
	logic [`ADDR_W-1:0] address;
	blob_pkg::mem_word_u data_write;
	logic wren, done;

	logic [15:0] stim [n_tests*test_words];
	logic [`WORD_W-1:0] mem [mem_words];
	logic [`WORD_W-1:0] init_mem [mem_words];
	logic [`WORD_W-1:0] exp_mem [mem_words];
	logic [`WORD_W-1:0] prev_mem [mem_words];
	int lab [area];
	int errors, passed, n_blobs, n_pixels;
	int mon_errors = 0;
	int wr_count = 0;
	logic wren_q = 1'b0;
	logic pause_on, load_now;

	blob_extraction uut (
		.clk(clk),
		.rst_n(rst_n),
		.enable(enable),
		.pause(pause),
		.data_read(data_read),
		.address(address),
		.data_write(data_write),
		.wren(wren),
		.done(done)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	// Frame memory, one cycle read latency
	always @(posedge clk) begin
		if (load_now)
			foreach (mem[a]) mem[a] <= init_mem[a];
		else if (wren)
			mem[address] <= data_write;
		data_read <= mem[address];
	end

	initial begin
		int seed_ret;
		seed_ret = $urandom(32'h351b7e06);
		forever begin
			@(posedge clk);
			pause <= pause_on && (($urandom % 8) == 0);
		end
	end

	// Write bus monitor, sampled on the edge that commits the write
	always @(posedge clk) begin
		if (rst_n) begin
			if (wren)
				wr_count = wr_count + 1;
			if (wren && pause) begin
				mon_errors = mon_errors + 1;
				$display("ERR %0t: wren high while pause is high", $time);
			end
			if (wren && wren_q) begin
				mon_errors = mon_errors + 1;
				$display("ERR %0t: writes in two consecutive cycles", $time);
			end
		end
		wren_q = wren;
	end

	initial begin
		repeat (limit + 10) @(posedge clk);
		$display("Timeout: the DUT did not finish within %0d cycles", limit);
		$display("Some tests failed");
		$finish;
	end

	function automatic logic fillable(int t, int x, int y);
		logic [15:0] row;
		if (x < `IMG_MARGIN || x >= `IMG_W - `IMG_MARGIN)
			return 1'b0;
		if (y < `IMG_MARGIN || y >= `IMG_H - `IMG_MARGIN)
			return 1'b0;
		row = stim[t*test_words + 1 + y];
		return !row[4'(15 - x)]; // Bit 15 is x = 0
	endfunction

	function automatic logic [`WORD_W-1:0] fill_word(int a);
		logic [9:0] a10;
		a10 = 10'(a);
		return {6'h2b, a10, 6'h15, a10};
	endfunction

	task automatic load_frame(input int t);
		logic [15:0] row;
		for (int a = 0; a < mem_words; a++) begin
			row = stim[t*test_words + 1 + a / `IMG_W];
			init_mem[a] = (a < area) ? {31'b0, row[4'(15 - a % `IMG_W)]} : fill_word(a);
			exp_mem[a] = init_mem[a];
		end
		@(posedge clk) load_now <= 1'b1;
		@(posedge clk) load_now <= 1'b0;
	endtask

	// 4-connected flood from each unlabelled seed, seeds in raster order
	task automatic label_reference(input int t);
		int q[$];
		int x, y, p, px, py, nx, ny, k, lbl, cnt, x0, y0, x1, y1;
		n_blobs = 0;
		n_pixels = 0;
		foreach (lab[i]) lab[i] = 0;
		for (y = 0; y < `IMG_H; y++) begin
			for (x = 0; x < `IMG_W; x++) begin
				if (fillable(t, x, y) && lab[y*`IMG_W + x] == 0) begin
					lbl = `FIRST_LABEL + n_blobs;
					lab[y*`IMG_W + x] = lbl;
					q.push_back(y*`IMG_W + x);
					cnt = 0;
					x0 = x;
					x1 = x;
					y0 = y;
					y1 = y;
					while (q.size() > 0) begin
						p = q.pop_front();
						px = p % `IMG_W;
						py = p / `IMG_W;
						cnt++;
						x0 = (px < x0) ? px : x0;
						x1 = (px > x1) ? px : x1;
						y0 = (py < y0) ? py : y0;
						y1 = (py > y1) ? py : y1;
						exp_mem[p] = lbl;
						for (k = 0; k < 4; k++) begin
							nx = px + ((k == 0) ? 1 : (k == 1) ? -1 : 0);
							ny = py + ((k == 2) ? 1 : (k == 3) ? -1 : 0);
							if (fillable(t, nx, ny) && lab[ny*`IMG_W + nx] == 0) begin
								lab[ny*`IMG_W + nx] = lbl;
								q.push_back(ny*`IMG_W + nx);
							end
						end
					end
					exp_mem[`REC_BASE + 2*lbl] = cnt; // Count word
					exp_mem[`REC_BASE + 2*lbl + 1] = {8'(x0), 8'(y0), 8'(x1), 8'(y1)};
					n_blobs++;
					n_pixels += cnt;
				end
			end
		end
	endtask

	task automatic check_memory(input string phase);
		int shown;
		shown = 0;
		for (int a = 0; a < mem_words; a++) begin
			if (mem[a] !== exp_mem[a]) begin
				errors++;
				if (shown < 6)
					$display("ERR %0t: %s, %s word %0d is %h, expected %h", $time, phase,
						(a >= `REC_BASE) ? "record" : "pixel", a, mem[a], exp_mem[a]);
				shown++;
			end
		end
	endtask

	task automatic wait_done();
		do @(negedge clk); while (done !== 1'b1);
	endtask

	task automatic run_test(input int t);
		int start_errs, start_wr;
		logic same_frame;
		start_errs = errors + mon_errors;
		load_frame(t);
		label_reference(t);
		@(negedge clk);
		if (wren !== 1'b0 || done !== 1'b0) begin
			errors++;
			$display("ERR %0t: wren or done not low before enable", $time);
		end
		pause_on = stim[t*test_words][0];
		start_wr = wr_count;
		@(posedge clk) enable <= 1'b1;
		wait_done();
		pause_on = 1'b0;
		check_memory("first run");
		if (wr_count - start_wr != n_pixels + 2*n_blobs) begin
			errors++;
			$display("ERR %0t: %0d writes, expected %0d", $time, wr_count - start_wr,
				n_pixels + 2*n_blobs);
		end
		repeat (4) begin
			@(negedge clk);
			if (done !== 1'b1) begin
				errors++;
				$display("ERR %0t: done fell while enable high", $time);
			end
		end
		@(posedge clk) enable <= 1'b0;
		@(negedge clk);
		@(negedge clk);
		if (done !== 1'b0) begin
			errors++;
			$display("ERR %0t: done still high after enable fell", $time);
		end
		// Same pixels as the previous test, so the memory must match it word for word
		same_frame = (t > 0);
		for (int k = 1; k < test_words; k++)
			if (t > 0 && stim[t*test_words + k] != stim[(t-1)*test_words + k])
				same_frame = 1'b0;
		for (int a = 0; a < mem_words; a++) begin
			if (same_frame && mem[a] !== prev_mem[a]) begin
				errors++;
				$display("ERR %0t: word %0d is %h, test %0d left %h", $time, a, mem[a], t - 1,
					prev_mem[a]);
			end
			prev_mem[a] = mem[a];
		end
		start_wr = wr_count;
		@(posedge clk) enable <= 1'b1; // Rerun on the labelled frame
		wait_done();
		if (wr_count != start_wr) begin
			errors++;
			$display("ERR %0t: second run wrote %0d words", $time, wr_count - start_wr);
		end
		check_memory("second run");
		@(posedge clk) enable <= 1'b0;
		repeat (3) @(negedge clk);
		if (errors + mon_errors == start_errs)
			passed++;
		$display("Test %0d: %s, %0d blobs, %0d pixels, pause %0d", t,
			(errors + mon_errors == start_errs) ? "ok" : "FAILED", n_blobs, n_pixels,
			stim[t*test_words][0]);
	endtask

	initial begin
		int total;
		rst_n = 1'b0;
		enable = 1'b0;
		load_now = 1'b0;
		pause_on = 1'b0;
		errors = 0;
		passed = 0;
		$readmemh("test/blob_input.txt", stim);
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		total = errors + mon_errors;
		$display("Summary: %0d of %0d tests ok, %0d errors", passed, n_tests, total);
		if (total == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== test/blob_input.txt ====
// Per test: pause flag, then frame rows y=0..11 as 16-bit hex, four rows a line
// Bit 15 is x=0, a set bit is a nonzero pixel and a clear bit a zero pixel
// Mixed blobs, a ring, zero pixels on the right border
0
FFFF 9FE1 9DED F8ED
FDE1 8FFF B73E 873E
FFFE D5C7 D58F FFFF
// Same frame with random pause pulses
1
FFFF 9FE1 9DED F8ED
FDE1 8FFF B73E 873E
FFFE D5C7 D58F FFFF
// Comb with a left spine and five teeth
1
FFFF 8001 BFFF 8001
BFFF 8001 BFFF 8001
BFFF 8001 BFFF FFFF
// Zero border, U-shaped region and single pixels
0
0000 00FE 7EC0 66DE
66DE 7E1E 5554 7FFE
0000 7FFE 4002 0000

// ==== tb.f ====
+incdir+design
design/blob_pkg.sv
design/fill_stack.sv
design/blob_stats.sv
design/mem_access.sv
design/blob_ctrl.sv
design/blob_extraction.sv
test/tb_blob_extraction.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the blob labeller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_blob_extraction \
	--Mdir obj_dir -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -qx "All tests passed" sim.log; then
	echo "Simulation PASSED"
else
	echo "Simulation FAILED"
	exit 1
fi
